/* design/corner_turn_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module corner_turn_buffer #(
  parameter int W = 18                                      // complex word width
) (
  input  logic       clk,
  input  logic       arst_n_i,
  cplx_stream_if.snk in_s,                                  // row-major samples
  cplx_stream_if.src out_s                                  // column-major samples
);

  localparam int SIDE_W = $clog2(fft2d_pkg::dft_points);    // row or column index width
  localparam int ADDR_W = $clog2(fft2d_pkg::frame_samples); // {row, col}

  fft2d_pkg::turn_state_e state;                            // FILL or DRAIN

  logic signed [W-1:0] mem_re [0:fft2d_pkg::frame_samples-1];
  logic signed [W-1:0] mem_im [0:fft2d_pkg::frame_samples-1];

  logic [ADDR_W-1:0] wr_cnt;                                // linear write address
  logic [ADDR_W:0]   rd_cnt;                                // reads issued, msb = all issued
  logic [ADDR_W-1:0] rd_addr;                               // transposed read address

  logic                out_valid_q;                         // output register full
  logic signed [W-1:0] out_re_q;
  logic signed [W-1:0] out_im_q;

  logic in_fire;
  logic out_fire;
  logic rd_issue;                                           // load output register
  logic drain_done;                                         // last item leaving

  assign in_s.ready  = (state == fft2d_pkg::FILL);
  assign out_s.valid = out_valid_q;
  assign out_s.re    = out_re_q;
  assign out_s.im    = out_im_q;

  assign in_fire  = in_s.valid & in_s.ready;
  assign out_fire = out_valid_q & out_s.ready;

  // item k reads column k[hi], row k[lo], address is {row, col}
  assign rd_addr = {rd_cnt[SIDE_W-1:0], rd_cnt[ADDR_W-1:SIDE_W]};

  // next read only once the held word has gone
  assign rd_issue = (state == fft2d_pkg::DRAIN) && !rd_cnt[ADDR_W]
                    && (!out_valid_q || out_s.ready);

  assign drain_done = out_fire && rd_cnt[ADDR_W];           // nothing left to issue

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state       <= fft2d_pkg::FILL;
      wr_cnt      <= '0;
      rd_cnt      <= '0;
      out_valid_q <= 1'b0;
    end
    else
    begin
      if (in_fire)
        wr_cnt <= wr_cnt + 1'b1;                            // wraps to 0 after the frame
      if (rd_issue)
        rd_cnt <= rd_cnt + 1'b1;
      else if (drain_done)
        rd_cnt <= '0;

      if (rd_issue)
        out_valid_q <= 1'b1;
      else if (out_fire)
        out_valid_q <= 1'b0;

      case (state)
        fft2d_pkg::FILL:
        begin
          if (in_fire && (wr_cnt == '1))
            state <= fft2d_pkg::DRAIN;                      // first read next cycle
        end
        default:
        begin
          if (drain_done)
            state <= fft2d_pkg::FILL;                       // sixteenth output taken
        end
      endcase
    end
  end

  // frame memory and output data register
  always_ff @(posedge clk)
  begin
    if (in_fire)
    begin
      mem_re[wr_cnt] <= in_s.re;
      mem_im[wr_cnt] <= in_s.im;
    end
    if (rd_issue)
    begin
      out_re_q <= mem_re[rd_addr];
      out_im_q <= mem_im[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* design/cplx_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one complex sample per transfer, valid/ready handshake
interface cplx_stream_if #(
  parameter int W = 16                                      // width of re and im
) ();

  logic                valid;                               // source has a sample
  logic                ready;                               // sink takes it this edge
  logic signed [W-1:0] re;                                  // real part
  logic signed [W-1:0] im;                                  // imaginary part

  // producer side, holds data until valid && ready
  modport src (
    output valid,
    output re,
    output im,
    input  ready
  );

  // consumer side
  modport snk (
    input  valid,
    input  re,
    input  im,
    output ready
  );

endinterface

`default_nettype wire

/* design/dft4_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module dft4_stage #(
  parameter int IN_W = 16                                   // input word width
) (
  input  logic       clk,
  input  logic       arst_n_i,
  cplx_stream_if.snk in_s,                                  // IN_W wide samples
  cplx_stream_if.src out_s                                  // IN_W + stage_growth wide bins
);

  localparam int OUT_W = IN_W + fft2d_pkg::stage_growth;    // bin width
  localparam int CNT_W = $clog2(fft2d_pkg::dft_points);     // sample index width
  localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(fft2d_pkg::dft_points - 1);

  fft2d_pkg::dft_state_e state;                             // COLLECT or EMIT
  logic [CNT_W-1:0] in_cnt;                                 // next input slot
  logic [CNT_W-1:0] out_cnt;                                // bin being offered

  // a, b, c are held here, d is used straight off the input
  logic signed [IN_W-1:0] samp_re [0:fft2d_pkg::dft_points-2];
  logic signed [IN_W-1:0] samp_im [0:fft2d_pkg::dft_points-2];

  logic signed [OUT_W-1:0] bin_re [0:fft2d_pkg::dft_points-1]; // X0..X3
  logic signed [OUT_W-1:0] bin_im [0:fft2d_pkg::dft_points-1];

  logic in_fire;                                            // input transfer this edge
  logic out_fire;                                           // output transfer this edge
  logic in_last;                                            // fourth sample arriving

  logic signed [OUT_W-1:0] a_re, a_im;                      // sign extended operands
  logic signed [OUT_W-1:0] b_re, b_im;
  logic signed [OUT_W-1:0] c_re, c_im;
  logic signed [OUT_W-1:0] d_re, d_im;
  logic signed [OUT_W-1:0] sum_ac_re, sum_ac_im;            // a + c
  logic signed [OUT_W-1:0] sum_bd_re, sum_bd_im;            // b + d
  logic signed [OUT_W-1:0] dif_ac_re, dif_ac_im;            // a - c
  logic signed [OUT_W-1:0] dif_bd_re, dif_bd_im;            // b - d

  // handshake
  assign in_s.ready  = (state == fft2d_pkg::COLLECT);
  assign out_s.valid = (state == fft2d_pkg::EMIT);
  assign out_s.re    = bin_re[out_cnt];                     // held while not ready
  assign out_s.im    = bin_im[out_cnt];

  assign in_fire  = in_s.valid & in_s.ready;
  assign out_fire = out_s.valid & out_s.ready;
  assign in_last  = (in_cnt == LAST_IDX);

  // widen before adding, growth stays exact
  assign a_re = OUT_W'(samp_re[0]);
  assign a_im = OUT_W'(samp_im[0]);
  assign b_re = OUT_W'(samp_re[1]);
  assign b_im = OUT_W'(samp_im[1]);
  assign c_re = OUT_W'(samp_re[2]);
  assign c_im = OUT_W'(samp_im[2]);
  assign d_re = OUT_W'(in_s.re);                            // fourth sample, live
  assign d_im = OUT_W'(in_s.im);

  // first butterfly layer
  assign sum_ac_re = a_re + c_re;
  assign sum_ac_im = a_im + c_im;
  assign sum_bd_re = b_re + d_re;
  assign sum_bd_im = b_im + d_im;
  assign dif_ac_re = a_re - c_re;
  assign dif_ac_im = a_im - c_im;
  assign dif_bd_re = b_re - d_re;
  assign dif_bd_im = b_im - d_im;

  // control, counters wrap at dft_points
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state   <= fft2d_pkg::COLLECT;
      in_cnt  <= '0;
      out_cnt <= '0;
    end
    else
    begin
      case (state)
        fft2d_pkg::COLLECT:
        begin
          if (in_fire)
          begin
            in_cnt <= in_cnt + 1'b1;
            if (in_last)
              state <= fft2d_pkg::EMIT;                     // bins ready next cycle
          end
        end
        default:
        begin
          if (out_fire)
          begin
            out_cnt <= out_cnt + 1'b1;
            if (out_cnt == LAST_IDX)
              state <= fft2d_pkg::COLLECT;                  // X3 gone
          end
        end
      endcase
    end
  end

  // sample store and bin registers
  always_ff @(posedge clk)
  begin
    if (in_fire && !in_last)
    begin
      samp_re[in_cnt] <= in_s.re;
      samp_im[in_cnt] <= in_s.im;
    end
    if (in_fire && in_last)
    begin
      bin_re[0] <= sum_ac_re + sum_bd_re;                   // a + b + c + d
      bin_im[0] <= sum_ac_im + sum_bd_im;
      bin_re[1] <= dif_ac_re + dif_bd_im;                   // -j*(b-d) swaps re/im
      bin_im[1] <= dif_ac_im - dif_bd_re;
      bin_re[2] <= sum_ac_re - sum_bd_re;                   // a - b + c - d
      bin_im[2] <= sum_ac_im - sum_bd_im;
      bin_re[3] <= dif_ac_re - dif_bd_im;                   // +j*(b-d)
      bin_im[3] <= dif_ac_im + dif_bd_re;
    end
  end

endmodule

`default_nettype wire

/* design/fft2d_pkg.sv */
`default_nettype none

package fft2d_pkg;

  // frame geometry
  localparam int dft_points    = 4;                         // points per 1-D DFT, also frame side
  localparam int frame_samples = dft_points * dft_points;   // 4x4 frame

  // word widths, two bits of growth per 4-point stage
  localparam int sample_w     = 16;                         // input sample width
  localparam int stage_growth = 2;                          // log2 of dft_points
  localparam int row_w        = sample_w + stage_growth;    // after row DFT
  localparam int col_w        = row_w + stage_growth;       // after column DFT, output width

  // dft4_stage sequencing
  typedef enum logic {
    COLLECT = 1'b0,                                         // taking in four samples
    EMIT    = 1'b1                                          // sending out four bins
  } dft_state_e;

  // corner_turn_buffer sequencing
  typedef enum logic {
    FILL  = 1'b0,                                           // writing a frame in row order
    DRAIN = 1'b1                                            // reading it back in column order
  } turn_state_e;

endpackage

`default_nettype wire

/* design/fft2d_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fft2d_top (
  input  logic                                clk,
  input  logic                                arst_n_i,
  input  logic                                in_valid_i,   // row-major input samples
  output logic                                in_ready_o,
  input  logic signed [fft2d_pkg::sample_w-1:0] in_re_i,
  input  logic signed [fft2d_pkg::sample_w-1:0] in_im_i,
  output logic                                out_valid_o,  // column-major output bins
  input  logic                                out_ready_i,
  output logic signed [fft2d_pkg::col_w-1:0]  out_re_o,
  output logic signed [fft2d_pkg::col_w-1:0]  out_im_o
);

  cplx_stream_if #(.W(fft2d_pkg::sample_w)) in_s  ();       // port side input
  cplx_stream_if #(.W(fft2d_pkg::row_w))    row_s ();       // row DFT to corner turn
  cplx_stream_if #(.W(fft2d_pkg::row_w))    col_s ();       // corner turn to column DFT
  cplx_stream_if #(.W(fft2d_pkg::col_w))    out_s ();       // port side output

  // plain ports onto the streams
  assign in_s.valid  = in_valid_i;
  assign in_s.re     = in_re_i;
  assign in_s.im     = in_im_i;
  assign in_ready_o  = in_s.ready;

  assign out_valid_o = out_s.valid;
  assign out_re_o    = out_s.re;
  assign out_im_o    = out_s.im;
  assign out_s.ready = out_ready_i;

  // 1-D DFT along each row
  dft4_stage #(
    .IN_W (fft2d_pkg::sample_w)
  ) u_row_dft (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .in_s     (in_s),
    .out_s    (row_s)
  );

  // transpose, one frame deep
  corner_turn_buffer #(
    .W (fft2d_pkg::row_w)
  ) u_turn (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .in_s     (row_s),
    .out_s    (col_s)
  );

  // 1-D DFT along each column
  dft4_stage #(
    .IN_W (fft2d_pkg::row_w)
  ) u_col_dft (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .in_s     (col_s),
    .out_s    (out_s)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Verilator build and run, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_fft2d \
  -f vlog.f -o tb_fft2d_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_fft2d_sim > sim.log 2>&1
cat sim.log

# a crash or a missing verdict counts as a failure too
grep -qF "*** FAILED ***" sim.log && { echo "simulation failed"; exit 1; }
grep -qF "*** PASSED ***" sim.log || { echo "simulation gave no verdict"; exit 1; }
echo "simulation passed"

/* testbench/fft2d_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module fft2d_sva (
  input logic                                 clk,
  input logic                                 arst_n_i,
  input logic                                 in_valid_i,
  input logic                                 in_ready_o,
  input logic signed [fft2d_pkg::sample_w-1:0] in_re_i,
  input logic signed [fft2d_pkg::sample_w-1:0] in_im_i,
  input logic                                 out_valid_o,
  input logic                                 out_ready_i,
  input logic signed [fft2d_pkg::col_w-1:0]    out_re_o,
  input logic signed [fft2d_pkg::col_w-1:0]    out_im_o
);

  // stalled input sample stays offered and unchanged
  in_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_re_i) && $stable(in_im_i))
    else $error("input sample withdrawn or changed while stalled");

  // stalled output bin held
  out_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_re_o) && $stable(out_im_o))
    else $error("output bin withdrawn or changed while stalled");

  reset_quiet_a: assert property (@(posedge clk) !arst_n_i |-> !out_valid_o)
    else $error("out_valid_o high during reset");

endmodule

bind fft2d_top fft2d_sva u_sva (.*);

`default_nettype wire

/* testbench/tb_fft2d.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fft2d;

  localparam int n_pts          = fft2d_pkg::dft_points;
  localparam int n_samp         = fft2d_pkg::frame_samples;
  localparam int frame_count    = 53;                       // 1 + 20 + 20 + 8 + 4
  localparam int timeout_cycles = 100 * frame_count + 200;
  localparam int s_max          = 2 ** (fft2d_pkg::sample_w - 1) - 1;
  localparam int s_min          = -(2 ** (fft2d_pkg::sample_w - 1));

  logic                                 clk;
  logic                                 arst_n_i;
  logic                                 in_valid_i;
  logic                                 in_ready_o;
  logic signed [fft2d_pkg::sample_w-1:0] in_re_i;
  logic signed [fft2d_pkg::sample_w-1:0] in_im_i;
  logic                                 out_valid_o;
  logic                                 out_ready_i;
  logic signed [fft2d_pkg::col_w-1:0]    out_re_o;
  logic signed [fft2d_pkg::col_w-1:0]    out_im_o;

  integer seed       = 32'h16a4e1ef;                        // sample data and input gaps
  integer ready_seed = ~32'h16a4e1ef;                       // sink stalls, own stream
  bit     bp_mode;                                          // random out_ready_i when set
  string  test_name;
  int     errors;
  int     cycle_cnt;
  int     in_count;                                         // input transfers seen
  int     out_count;                                        // output transfers seen
  int     exp_total;                                        // results pushed by the model
  int     exp_re_q [$];
  int     exp_im_q [$];
  int     fr_re [0:n_samp-1];                               // current frame, row-major
  int     fr_im [0:n_samp-1];

  fft2d_top DUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;                                 // 100 ns period
  end

  // DFT twiddle W4^m applied to (re, im), m = 1 is -j
  function automatic int twiddle_re(int re, int im, int m);
    case (m)
      0:       return re;
      1:       return im;
      2:       return -re;
      default: return -im;
    endcase
  endfunction

  function automatic int twiddle_im(int re, int im, int m);
    case (m)
      0:       return im;
      1:       return -re;
      2:       return -im;
      default: return re;
    endcase
  endfunction

  // kind 0 impulse, 1 random, 2 all max, 3 all min, else random max/min mix
  function automatic int sample_value(int kind, int pos, int rnd);
    case (kind)
      0:       return (pos == 0) ? 1000 : 0;
      1:       return rnd;
      2:       return s_max;
      3:       return s_min;
      default: return rnd[0] ? s_max : s_min;
    endcase
  endfunction

  task automatic fill_frame(input int kind);
    logic signed [fft2d_pkg::sample_w-1:0] r;
    logic signed [fft2d_pkg::sample_w-1:0] q;
    for (int i = 0; i < n_samp; i++)
    begin
      r = $random(seed);                                    // kept to sample_w bits
      q = $random(seed);
      fr_re[i] = sample_value(kind, i, r);
      fr_im[i] = sample_value(kind, i + n_samp, q);         // impulse has no imaginary part
    end
  endtask

  // direct 2-D DFT, rows then columns, pushed column-major in frequency order
  task automatic model_frame();
    int row_re [0:n_samp-1];
    int row_im [0:n_samp-1];
    int acc_re;
    int acc_im;
    for (int r = 0; r < n_pts; r++)
      for (int k = 0; k < n_pts; k++)
      begin
        acc_re = 0;
        acc_im = 0;
        for (int n = 0; n < n_pts; n++)
        begin
          acc_re += twiddle_re(fr_re[r*n_pts+n], fr_im[r*n_pts+n], (n * k) % n_pts);
          acc_im += twiddle_im(fr_re[r*n_pts+n], fr_im[r*n_pts+n], (n * k) % n_pts);
        end
        row_re[r*n_pts+k] = acc_re;
        row_im[r*n_pts+k] = acc_im;
      end
    for (int c = 0; c < n_pts; c++)                         // column outer
      for (int k = 0; k < n_pts; k++)                       // frequency row inner
      begin
        acc_re = 0;
        acc_im = 0;
        for (int r = 0; r < n_pts; r++)
        begin
          acc_re += twiddle_re(row_re[r*n_pts+c], row_im[r*n_pts+c], (r * k) % n_pts);
          acc_im += twiddle_im(row_re[r*n_pts+c], row_im[r*n_pts+c], (r * k) % n_pts);
        end
        exp_re_q.push_back(acc_re);
        exp_im_q.push_back(acc_im);
        exp_total++;
      end
  endtask

  // one sample, valid held until in_ready_o seen before a rising edge
  task automatic drive_sample(input int re, input int im, input bit gaps);
    @(negedge clk);
    while (gaps && (($random(seed) & 3) == 0))
    begin
      in_valid_i = 1'b0;                                    // idle slot
      @(negedge clk);
    end
    in_valid_i = 1'b1;
    in_re_i    = re[fft2d_pkg::sample_w-1:0];
    in_im_i    = im[fft2d_pkg::sample_w-1:0];
    while (!in_ready_o)                                     // ready only moves on posedge
      @(negedge clk);
    @(posedge clk);                                         // transfer edge
  endtask

  task automatic send_frame(input bit gaps);
    model_frame();
    for (int i = 0; i < n_samp; i++)
      drive_sample(fr_re[i], fr_im[i], gaps);
  endtask

  // wait for all results, then a few idle cycles to catch extra outputs
  task automatic end_test();
    @(negedge clk);
    in_valid_i = 1'b0;
    while (exp_re_q.size() != 0)
      @(posedge clk);
    repeat (4) @(posedge clk);
    assert (out_count == exp_total)
    else
    begin
      $display("[ERROR] %s: expected %0d outputs, actual %0d", test_name, exp_total, out_count);
      errors++;
    end
  endtask

  task automatic check_output();
    int e_re;
    int e_im;
    out_count++;
    if (exp_re_q.size() == 0)
    begin
      $display("output in test %s arrived with no result pending", test_name);
      errors++;
    end
    else
    begin
      e_re = exp_re_q.pop_front();
      e_im = exp_im_q.pop_front();
      assert (out_re_o == e_re && out_im_o == e_im)
      else
      begin
        $display("[ERROR] %s: expected re=%0d im=%0d, actual re=%0d im=%0d",
                 test_name, e_re, e_im, out_re_o, out_im_o);
        errors++;
      end
      if (test_name == "impulse")
        assert (out_re_o == 1000 && out_im_o == 0)
        else
        begin
          $display("[ERROR] impulse: expected re=1000 im=0, actual re=%0d im=%0d",
                   out_re_o, out_im_o);
          errors++;
        end
    end
  endtask

  task automatic report_and_finish();
    $display("errors: %0d, outputs: %0d of %0d", errors, out_count, exp_total);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  endtask

  // output monitor, looks late in the low phase when every signal has settled
  always @(negedge clk)
  begin
    #25;
    if (arst_n_i)
    begin
      assert (!out_valid_o || in_count >= n_samp)
      else
      begin
        $display("out_valid_o went high before a full frame was accepted");
        errors++;
      end
      if (in_valid_i && in_ready_o)
        in_count++;                                         // transfer on coming edge
      if (out_valid_o && out_ready_i)
        check_output();
    end
  end

  always @(negedge clk)
    out_ready_i = bp_mode ? (($random(ready_seed) & 1) != 0) : 1'b1;   // sink stalls

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt == timeout_cycles)
    begin
      $display("timeout: run still busy after %0d cycles", cycle_cnt);
      errors++;
      report_and_finish();
    end
  end

  initial
  begin
    arst_n_i    = 1'b0;
    in_valid_i  = 1'b0;
    in_re_i     = '0;
    in_im_i     = '0;
    out_ready_i = 1'b1;
    bp_mode     = 1'b0;
    test_name   = "reset";
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;
    @(negedge clk);
    assert (in_ready_o && !out_valid_o)
    else
    begin
      $display("[ERROR] reset: expected in_ready_o=1 out_valid_o=0, actual %b %b",
               in_ready_o, out_valid_o);
      errors++;
    end

    test_name = "impulse";
    fill_frame(0);
    send_frame(1'b0);
    end_test();

    test_name = "random";
    for (int f = 0; f < 20; f++)
    begin
      fill_frame(1);
      send_frame(1'b0);
    end
    end_test();

    test_name = "backpressure";
    bp_mode   = 1'b1;                                       // also gaps on the input
    for (int f = 0; f < 20; f++)
    begin
      fill_frame(1);
      send_frame(1'b1);
    end
    end_test();
    bp_mode = 1'b0;

    test_name = "back_to_back";
    for (int f = 0; f < 8; f++)
    begin
      fill_frame(1);
      send_frame(1'b0);
    end
    end_test();

    test_name = "extremes";
    for (int k = 2; k < 6; k++)                             // max, min, two mixed frames
    begin
      fill_frame(k);
      send_frame(1'b0);
    end
    end_test();

    report_and_finish();
  end

endmodule

`default_nettype wire

/* vlog.f */
design/fft2d_pkg.sv
design/cplx_stream_if.sv
design/dft4_stage.sv
design/corner_turn_buffer.sv
design/fft2d_top.sv
testbench/fft2d_sva.sv
testbench/tb_fft2d.sv
